//--- hw/rv32_pkg.sv
package rv32_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int BYTE_EN_W  = 4;
    localparam logic [XLEN-1:0] RESET_PC = '0;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;   // sub, sra, srai
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    localparam int DIV_STEPS = 32;
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_LOAD, WB_PC_PLUS_4, WB_DIV
    } wb_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

endpackage

//--- hw/rv32_decoder.sv
`timescale 1ns/1ps

module rv32_decoder (
    input  rv32_pkg::inst_u                     i_inst,
    output logic [rv32_pkg::REG_ADDR_W-1:0]     o_rs1,
    output logic [rv32_pkg::REG_ADDR_W-1:0]     o_rs2,
    output logic [rv32_pkg::REG_ADDR_W-1:0]     o_rd,
    output logic [rv32_pkg::XLEN-1:0]           o_imm,
    output rv32_pkg::alu_op_e                   o_alu_op,
    output logic                                o_use_imm,
    output logic                                o_use_pc,
    output logic                                o_branch,
    output logic                                o_jal,
    output logic                                o_jalr,
    output logic                                o_load,
    output logic                                o_store,
    output logic [1:0]                          o_mem_size,
    output logic                                o_mem_unsigned,
    output rv32_pkg::wb_sel_e                   o_wb_sel,
    output logic                                o_reg_we,
    output logic                                o_div,
    output logic                                o_div_signed,
    output logic                                o_div_rem
);
    import rv32_pkg::*;

    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;

    // funct3 to alu operation, alt picks sub / sra
    function automatic alu_op_e f3_op(input logic [2:0] f, input logic alt);
        case (f)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = i_inst.r.opcode;
    assign f3     = i_inst.r.funct3;
    assign f7     = i_inst.r.funct7;
    assign o_rs1  = i_inst.r.rs1;
    assign o_rs2  = i_inst.r.rs2;
    assign o_rd   = i_inst.r.rd;
    assign o_mem_size     = f3[1:0];   // byte, half, word
    assign o_mem_unsigned = f3[2];     // lbu, lhu
    assign o_div_signed   = ~f3[0];    // div, rem
    assign o_div_rem      = f3[1];

    always_comb begin
        o_imm     = {{20{i_inst.i.imm_11_0[11]}}, i_inst.i.imm_11_0};
        o_alu_op  = ALU_ADD;
        o_use_imm = 1'b0;
        o_use_pc  = 1'b0;
        o_branch  = 1'b0;
        o_jal     = 1'b0;
        o_jalr    = 1'b0;
        o_load    = 1'b0;
        o_store   = 1'b0;
        o_wb_sel  = WB_ALU;
        o_reg_we  = 1'b0;
        o_div     = 1'b0;
        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                o_imm     = {i_inst.u.imm_31_12, 12'h000};
                o_use_imm = 1'b1;
                o_use_pc  = (opcode == OPC_AUIPC);
                o_alu_op  = (opcode == OPC_LUI) ? ALU_PASS_B : ALU_ADD;
                o_reg_we  = 1'b1;
            end
            OPC_JAL: begin
                o_imm    = {{11{i_inst.j.imm_20}}, i_inst.j.imm_20, i_inst.j.imm_19_12,
                            i_inst.j.imm_11, i_inst.j.imm_10_1, 1'b0};
                o_jal    = 1'b1;
                o_wb_sel = WB_PC_PLUS_4;
                o_reg_we = 1'b1;
            end
            OPC_JALR: begin
                o_jalr    = (f3 == 3'b000);
                o_use_imm = 1'b1;            // target from rs1 + imm
                o_wb_sel  = WB_PC_PLUS_4;
                o_reg_we  = (f3 == 3'b000);
            end
            OPC_BRANCH: begin
                o_imm    = {{19{i_inst.b.imm_12}}, i_inst.b.imm_12, i_inst.b.imm_11,
                            i_inst.b.imm_10_5, i_inst.b.imm_4_1, 1'b0};
                o_branch = (f3[2:1] != 2'b01);   // 010, 011 undefined
            end
            OPC_LOAD: begin
                o_use_imm = 1'b1;
                o_wb_sel  = WB_LOAD;
                o_load    = (f3 != 3'b011) && (f3[2:1] != 2'b11);
                o_reg_we  = o_load;
            end
            OPC_STORE: begin
                o_imm     = {{20{i_inst.s.imm_11_5[6]}}, i_inst.s.imm_11_5, i_inst.s.imm_4_0};
                o_use_imm = 1'b1;
                o_store   = ~f3[2] && (f3[1:0] != 2'b11);
            end
            OPC_OPIMM: begin
                o_use_imm = 1'b1;
                o_alu_op  = f3_op(f3, (f3 == 3'b101) && (f7 == F7_ALT));
                o_reg_we  = !((f3 == 3'b001) && (f7 != F7_BASE)) &&
                            !((f3 == 3'b101) && (f7 != F7_BASE) && (f7 != F7_ALT));
            end
            OPC_OP: begin
                o_alu_op = f3_op(f3, f7 == F7_ALT);
                if (f7 == F7_MULDIV) begin
                    o_div    = f3[2];            // multiply half not supported
                    o_wb_sel = WB_DIV;
                    o_reg_we = f3[2];
                end else begin
                    o_reg_we = (f7 == F7_BASE) ||
                               ((f7 == F7_ALT) && ((f3 == 3'b000) || (f3 == 3'b101)));
                end
            end
            default: ;
        endcase
    end

endmodule

//--- hw/rv32_regfile.sv
`timescale 1ns/1ps

module rv32_regfile (
    input  logic                             clk,
    input  logic                             clrn,
    input  logic [rv32_pkg::REG_ADDR_W-1:0]  i_rs1,
    input  logic [rv32_pkg::REG_ADDR_W-1:0]  i_rs2,
    input  logic [rv32_pkg::REG_ADDR_W-1:0]  i_rd,
    input  logic                             i_we,
    input  logic [rv32_pkg::XLEN-1:0]        i_wdata,
    output logic [rv32_pkg::XLEN-1:0]        o_rdata1,
    output logic [rv32_pkg::XLEN-1:0]        o_rdata2
);
    import rv32_pkg::*;

    logic [XLEN-1:0] regs [1:NUM_REGS-1];   // x0 is not stored

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            for (int k = 1; k < NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rdata1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

//--- hw/rv32_alu.sv
`timescale 1ns/1ps

module rv32_alu (
    input  rv32_pkg::alu_op_e         i_op,
    input  logic [rv32_pkg::XLEN-1:0] i_a,
    input  logic [rv32_pkg::XLEN-1:0] i_b,
    input  logic [2:0]                i_funct3_branch,
    output logic [rv32_pkg::XLEN-1:0] o_result,
    output logic                      o_taken
);
    import rv32_pkg::*;

    logic [4:0] shamt;
    logic       signed_lt;
    logic       unsigned_lt;

    assign shamt       = i_b[4:0];
    assign signed_lt   = $signed(i_a) < $signed(i_b);
    assign unsigned_lt = i_a < i_b;

    always_comb begin
        case (i_op)
            ALU_ADD:    o_result = i_a + i_b;
            ALU_SUB:    o_result = i_a - i_b;
            ALU_AND:    o_result = i_a & i_b;
            ALU_OR:     o_result = i_a | i_b;
            ALU_XOR:    o_result = i_a ^ i_b;
            ALU_SLL:    o_result = i_a << shamt;
            ALU_SRL:    o_result = i_a >> shamt;
            ALU_SRA:    o_result = $signed(i_a) >>> shamt;
            ALU_SLT:    o_result = {{(XLEN-1){1'b0}}, signed_lt};
            ALU_SLTU:   o_result = {{(XLEN-1){1'b0}}, unsigned_lt};
            ALU_PASS_B: o_result = i_b;          // lui
            default:    o_result = i_a + i_b;
        endcase
    end

    // branch condition by funct3
    always_comb begin
        case (i_funct3_branch)
            3'b000:  o_taken = (i_a == i_b);    // beq
            3'b001:  o_taken = (i_a != i_b);    // bne
            3'b100:  o_taken = signed_lt;       // blt
            3'b101:  o_taken = ~signed_lt;      // bge
            3'b110:  o_taken = unsigned_lt;     // bltu
            3'b111:  o_taken = ~unsigned_lt;    // bgeu
            default: o_taken = 1'b0;
        endcase
    end

endmodule

//--- hw/rv32_divider.sv
`timescale 1ns/1ps

module rv32_divider (
    input  logic                      clk,
    input  logic                      clrn,
    input  logic                      i_start,
    input  logic                      i_signed,
    input  logic                      i_rem,
    input  logic [rv32_pkg::XLEN-1:0] i_dividend,
    input  logic [rv32_pkg::XLEN-1:0] i_divisor,
    output logic                      o_busy,
    output logic [rv32_pkg::XLEN-1:0] o_result
);
    import rv32_pkg::*;

    logic                 busy;
    logic [DIV_CNT_W-1:0] step;
    logic [XLEN-1:0]      quo;       // dividend shifts out, quotient shifts in
    logic [XLEN-1:0]      rem;
    logic [XLEN-1:0]      dvs;       // divisor magnitude
    logic                 neg_q;
    logic                 neg_r;
    logic                 rem_sel;
    logic                 div_zero;
    logic                 a_neg;
    logic                 b_neg;
    logic [XLEN:0]        rem_shift;
    logic [XLEN:0]        diff;

    assign a_neg = i_signed & i_dividend[XLEN-1];
    assign b_neg = i_signed & i_divisor[XLEN-1];

    assign rem_shift = {rem, quo[XLEN-1]};
    assign diff      = rem_shift - {1'b0, dvs};

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            busy <= 1'b0;
            step <= '0;
        end else if (i_start && !busy) begin
            busy <= 1'b1;
            step <= '0;
        end else if (busy) begin
            step <= step + 1'b1;
            if (step == DIV_CNT_W'(DIV_STEPS - 1)) begin
                busy <= 1'b0;                // result valid from here
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_start && !busy) begin
            quo      <= a_neg ? -i_dividend : i_dividend;
            dvs      <= b_neg ? -i_divisor : i_divisor;
            rem      <= '0;
            neg_q    <= a_neg ^ b_neg;
            neg_r    <= a_neg;
            rem_sel  <= i_rem;
            div_zero <= (i_divisor == '0);
        end else if (busy) begin
            if (diff[XLEN]) begin            // restore
                rem <= rem_shift[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b0};
            end else begin
                rem <= diff[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b1};
            end
        end
    end

    // sign fix-up, divide by zero gives all ones and the dividend back
    always_comb begin
        if (rem_sel) begin
            o_result = neg_r ? -rem : rem;
        end else if (div_zero) begin
            o_result = '1;
        end else begin
            o_result = neg_q ? -quo : quo;
        end
    end

    assign o_busy = busy;

endmodule

//--- hw/rv32_lsu.sv
`timescale 1ns/1ps

module rv32_lsu (
    input  logic [rv32_pkg::XLEN-1:0]      i_addr,
    input  logic [rv32_pkg::XLEN-1:0]      i_store_data,
    input  logic [rv32_pkg::XLEN-1:0]      i_rdata,
    input  logic [1:0]                     i_mem_size,
    input  logic                           i_mem_unsigned,
    input  logic                           i_load,
    input  logic                           i_store,
    output logic [rv32_pkg::XLEN-1:0]      o_addr,
    output logic [rv32_pkg::XLEN-1:0]      o_wdata,
    output logic [rv32_pkg::BYTE_EN_W-1:0] o_wmem,
    output logic [rv32_pkg::XLEN-1:0]      o_load_data
);
    import rv32_pkg::*;

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    assign lane_byte = i_rdata[8*i_addr[1:0] +: 8];
    assign lane_half = i_addr[1] ? i_rdata[31:16] : i_rdata[15:0];

    always_comb begin
        case (i_mem_size)
            2'b00: begin
                o_addr  = i_addr;
                o_wdata = {4{i_store_data[7:0]}};
                o_wmem  = BYTE_EN_W'(4'b0001 << i_addr[1:0]);
                o_load_data = {{24{lane_byte[7] & ~i_mem_unsigned}}, lane_byte};
            end
            2'b01: begin
                o_addr  = {i_addr[XLEN-1:1], 1'b0};
                o_wdata = {2{i_store_data[15:0]}};
                o_wmem  = i_addr[1] ? 4'b1100 : 4'b0011;
                o_load_data = {{16{lane_half[15] & ~i_mem_unsigned}}, lane_half};
            end
            default: begin
                o_addr  = {i_addr[XLEN-1:2], 2'b00};
                o_wdata = i_store_data;
                o_wmem  = 4'b1111;
                o_load_data = i_rdata;
            end
        endcase
        if (!i_store) begin
            o_wmem = '0;                     // no write outside stores
        end
        if (!i_load) begin
            o_load_data = '0;
        end
    end

endmodule

//--- hw/rv32_core.sv
`timescale 1ns/1ps

module rv32_core (
    input  logic                           clk,
    input  logic                           clrn,
    input  logic [rv32_pkg::XLEN-1:0]      i_inst,
    input  logic [rv32_pkg::XLEN-1:0]      i_mem_rdata,
    output logic [rv32_pkg::XLEN-1:0]      o_pc,
    output logic [rv32_pkg::XLEN-1:0]      o_mem_addr,
    output logic [rv32_pkg::XLEN-1:0]      o_mem_wdata,
    output logic [rv32_pkg::BYTE_EN_W-1:0] o_wmem
);
    import rv32_pkg::*;

    logic [REG_ADDR_W-1:0] rs1, rs2, rd;
    logic [XLEN-1:0]       imm;
    alu_op_e               alu_op;
    wb_sel_e               wb_sel;
    logic                  use_imm, use_pc, branch, jal, jalr, load, store;
    logic [1:0]            mem_size;
    logic                  mem_unsigned, reg_we, div, div_signed, div_rem;
    logic [XLEN-1:0]       rdata1, rdata2, alu_a, alu_b, alu_result;
    logic                  taken;
    logic [XLEN-1:0]       div_result, load_data, wb_data;
    logic                  div_busy, div_run, div_start, div_fin, pc_hold;
    logic [XLEN-1:0]       pc, pc_plus_4, next_pc;

    rv32_decoder rv32_decoder_inst (
        .i_inst(i_inst), .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm),
        .o_alu_op(alu_op), .o_use_imm(use_imm), .o_use_pc(use_pc), .o_branch(branch),
        .o_jal(jal), .o_jalr(jalr), .o_load(load), .o_store(store),
        .o_mem_size(mem_size), .o_mem_unsigned(mem_unsigned), .o_wb_sel(wb_sel),
        .o_reg_we(reg_we), .o_div(div), .o_div_signed(div_signed), .o_div_rem(div_rem)
    );

    rv32_regfile rv32_regfile_inst (
        .clk(clk), .clrn(clrn), .i_rs1(rs1), .i_rs2(rs2), .i_rd(rd),
        .i_we(reg_we & (~div | div_fin)),   // divide writes only at the end
        .i_wdata(wb_data), .o_rdata1(rdata1), .o_rdata2(rdata2)
    );

    assign alu_a = use_pc ? pc : rdata1;    // auipc
    assign alu_b = use_imm ? imm : rdata2;

    rv32_alu rv32_alu_inst (
        .i_op(alu_op), .i_a(alu_a), .i_b(alu_b), .i_funct3_branch(i_inst[14:12]),
        .o_result(alu_result), .o_taken(taken)
    );

    rv32_divider rv32_divider_inst (
        .clk(clk), .clrn(clrn), .i_start(div_start), .i_signed(div_signed),
        .i_rem(div_rem), .i_dividend(rdata1), .i_divisor(rdata2),
        .o_busy(div_busy), .o_result(div_result)
    );

    rv32_lsu rv32_lsu_inst (
        .i_addr(alu_result), .i_store_data(rdata2), .i_rdata(i_mem_rdata),
        .i_mem_size(mem_size), .i_mem_unsigned(mem_unsigned), .i_load(load),
        .i_store(store & clrn),             // no store while in reset
        .o_addr(o_mem_addr), .o_wdata(o_mem_wdata), .o_wmem(o_wmem),
        .o_load_data(load_data)
    );

    // divide sequence is start, 32 steps, then write and advance
    assign div_start = div & ~div_run;
    assign div_fin   = div & div_run & ~div_busy;
    assign pc_hold   = div & ~div_fin;

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            div_run <= 1'b0;
        end else if (div_start) begin
            div_run <= 1'b1;
        end else if (div_fin) begin
            div_run <= 1'b0;
        end
    end

    assign pc_plus_4 = pc + XLEN'(4);

    always_comb begin
        if (jalr) begin
            next_pc = {alu_result[XLEN-1:1], 1'b0};
        end else if (jal || (branch && taken)) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc_plus_4;
        end
    end

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            pc <= RESET_PC;
        end else if (!pc_hold) begin
            pc <= next_pc;
        end
    end

    always_comb begin
        case (wb_sel)
            WB_LOAD:      wb_data = load_data;
            WB_PC_PLUS_4: wb_data = pc_plus_4;    // link value
            WB_DIV:       wb_data = div_result;
            default:      wb_data = alu_result;
        endcase
    end

    assign o_pc = pc;

endmodule

//--- testbench/rv32_core_props.sv
`timescale 1ns/1ps

module rv32_core_props (
    input logic                           clk,
    input logic                           clrn,
    input logic [rv32_pkg::XLEN-1:0]      i_inst,
    input logic [rv32_pkg::XLEN-1:0]      i_pc,
    input logic [rv32_pkg::BYTE_EN_W-1:0] i_wmem
);
    import rv32_pkg::*;

    logic       is_div;
    logic       is_ctrl;
    logic       prev_div;
    logic [5:0] div_cnt;   // edges since a divide appeared

    assign is_div  = (i_inst[6:0] == OPC_OP) && (i_inst[31:25] == F7_MULDIV) && i_inst[14];
    assign is_ctrl = (i_inst[6:0] == OPC_JAL) || (i_inst[6:0] == OPC_JALR) ||
                     (i_inst[6:0] == OPC_BRANCH);

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            prev_div <= 1'b0;
            div_cnt  <= '0;
        end else begin
            prev_div <= is_div;
            if (is_div && !prev_div) begin
                div_cnt <= 6'd1;
            end else if (div_cnt != '0 && div_cnt < 6'd34) begin
                div_cnt <= div_cnt + 6'd1;
            end else begin
                div_cnt <= '0;
            end
        end
    end

    wmem_idle_in_reset: assert property (@(posedge clk) !clrn |-> i_wmem == '0)
        else $error("byte enables active during reset");

    wmem_legal: assert property (@(posedge clk) disable iff (!clrn)
        i_wmem inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111})
        else $error("byte enable pattern %b is not a legal access", i_wmem);

    pc_step: assert property (@(posedge clk) disable iff (!clrn)
        (!is_ctrl && !is_div) |=> i_pc == $past(i_pc) + 32'd4)
        else $error("pc did not advance by 4 after a plain instruction");

    div_hold: assert property (@(posedge clk) disable iff (!clrn)
        (div_cnt >= 6'd1 && div_cnt <= 6'd33) |-> $stable(i_pc))
        else $error("pc moved while the divider was running");

    div_done: assert property (@(posedge clk) disable iff (!clrn)
        (div_cnt == 6'd34) |-> i_pc == $past(i_pc) + 32'd4)
        else $error("pc did not advance by 4 when the divide finished");

endmodule

bind rv32_core rv32_core_props rv32_core_props_inst (
    .clk(clk), .clrn(clrn), .i_inst(i_inst), .i_pc(o_pc), .i_wmem(o_wmem)
);

//--- testbench/tb_rv32_core.sv
`timescale 1ns/1ps

module tb_rv32_core;
    import rv32_pkg::*;

    localparam int IMEM_WORDS = 1024;
    localparam int DMEM_WORDS = 512;

    logic        clk;
    logic        clrn = 1'b0;
    logic [31:0] i_inst = '0;
    logic [31:0] i_mem_rdata = '0;
    logic [31:0] o_pc;
    logic [31:0] o_mem_addr;
    logic [31:0] o_mem_wdata;
    logic [3:0]  o_wmem;

    logic [31:0] imem [0:IMEM_WORDS-1];
    logic [31:0] dmem [0:DMEM_WORDS-1];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [3:0]  exp_be [$];
    logic [31:0] lfsr = 32'h08711f50;
    logic [31:0] end_pc;
    int ip = 0;
    int res_off = 'h100;                // result words start here
    int val_errs = 0;
    int other_errs = 0;
    int cycles = 0;
    int limit;

    rv32_core rv32_core_inst (.*);

    function automatic logic [31:0] rtype(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] itype(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] stype(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] btype(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jtype(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic taken_ref(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // div divu rem remu with the riscv zero and overflow results
    function automatic logic [31:0] div_ref(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        logic [31:0] q;
        logic [31:0] r;
        if (b == 0) begin
            q = '1;
            r = a;
        end else if (!f3[0] && a == 32'h80000000 && b == '1) begin
            q = a;
            r = '0;
        end else if (!f3[0]) begin
            q = 32'($signed(a) / $signed(b));
            r = 32'($signed(a) % $signed(b));
        end else begin
            q = a / b;
            r = a % b;
        end
        return f3[1] ? r : q;
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[ip] = w;
        ip++;
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;                // addi adds a signed low part
        emit({hi[31:12], rd, OPC_LUI});
        emit(itype(v[11:0], rd, 3'd0, rd, OPC_OPIMM));
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] be);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_be.push_back(be);
    endtask

    task automatic store_result(input logic [4:0] rs, input logic [31:0] expected);
        emit(stype(12'(res_off), rs, 5'd0, 3'd2));
        expect_store(32'(res_off), expected, 4'hF);
        res_off += 4;
    endtask

    task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        logic [11:0] sh;
        logic [31:0] p;
        for (int round = 0; round < 2; round++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            imm = 12'(rand_bits(12));
            load_const(1, a);
            load_const(2, b);
            for (int f = 0; f < 8; f++) begin
                emit(rtype(F7_BASE, 2, 1, 3'(f), 3));
                store_result(3, alu_ref(3'(f), 1'b0, a, b));
                if (f == 0 || f == 5) begin
                    emit(rtype(F7_ALT, 2, 1, 3'(f), 3));
                    store_result(3, alu_ref(3'(f), 1'b1, a, b));
                end
                sh = (f == 1 || f == 5) ? {7'd0, imm[4:0]} : imm;
                emit(itype(sh, 1, 3'(f), 3, OPC_OPIMM));
                store_result(3, alu_ref(3'(f), 1'b0, a, sext12(sh)));
            end
            emit(itype({F7_ALT, imm[4:0]}, 1, 3'd5, 3, OPC_OPIMM));   // srai
            store_result(3, alu_ref(3'd5, 1'b1, a, {27'd0, imm[4:0]}));
        end
        emit({a[31:12], 5'd4, OPC_LUI});
        store_result(4, {a[31:12], 12'h000});
        p = 32'(ip * 4);
        emit({b[31:12], 5'd4, OPC_AUIPC});
        store_result(4, p + {b[31:12], 12'h000});
        for (int f = 0; f < 8; f++) begin
            for (int same = 0; same < 2 && f != 2 && f != 3; same++) begin
                a = rand_bits(32);
                b = same ? a : rand_bits(32);
                load_const(1, a);
                load_const(2, b);
                emit(btype(13'd12, 2, 1, 3'(f)));
                emit(itype(12'd1, 0, 3'd0, 3, OPC_OPIMM));   // not-taken marker
                emit(jtype(21'd8, 0));
                emit(itype(12'd2, 0, 3'd0, 3, OPC_OPIMM));   // taken marker
                store_result(3, taken_ref(3'(f), a, b) ? 32'd2 : 32'd1);
            end
        end
        p = 32'(ip * 4);
        emit(jtype(21'd8, 5));
        emit(itype(12'd99, 0, 3'd0, 5, OPC_OPIMM));
        store_result(5, p + 4);
        p = 32'(ip * 4);
        load_const(7, p + 16);
        emit(itype(12'd1, 7, 3'd0, 5, OPC_JALR));           // odd target has bit 0 dropped
        emit(itype(12'd99, 0, 3'd0, 5, OPC_OPIMM));
        store_result(5, p + 12);
        a = rand_bits(32);
        load_const(1, a);
        load_const(2, 32'h600);
        for (int k = 0; k < 4; k++) begin
            emit(stype(12'(k), 1, 2, 3'd0));
            expect_store(32'h600, {4{a[7:0]}}, 4'(1 << k));
        end
        emit(stype(12'd4, 1, 2, 3'd1));
        expect_store(32'h604, {2{a[15:0]}}, 4'b0011);
        emit(stype(12'd6, 1, 2, 3'd1));
        expect_store(32'h604, {2{a[15:0]}}, 4'b1100);
        emit(stype(12'd8, 1, 2, 3'd2));
        expect_store(32'h608, a, 4'hF);
        for (int k = 0; k < 4; k++) begin
            emit(itype(12'(8 + k), 2, 3'd0, 3, OPC_LOAD));
            store_result(3, {{24{a[8*k+7]}}, a[8*k +: 8]});
            emit(itype(12'(8 + k), 2, 3'd4, 3, OPC_LOAD));
            store_result(3, {24'd0, a[8*k +: 8]});
        end
        for (int k = 0; k < 2; k++) begin
            emit(itype(12'(8 + 2*k), 2, 3'd1, 3, OPC_LOAD));
            store_result(3, {{16{a[16*k+15]}}, a[16*k +: 16]});
            emit(itype(12'(8 + 2*k), 2, 3'd5, 3, OPC_LOAD));
            store_result(3, {16'd0, a[16*k +: 16]});
        end
        emit(itype(12'd8, 2, 3'd2, 3, OPC_LOAD));
        store_result(3, a);
        for (int round = 0; round < 5; round++) begin
            a = (round == 4) ? 32'h80000000 : rand_bits(32);
            b = (round == 3) ? 32'd0 : (round == 4) ? '1 : rand_bits(32) >> round * 8;
            load_const(1, a);
            load_const(2, b);
            for (int f = 4; f < 8; f++) begin
                emit(rtype(F7_MULDIV, 2, 1, 3'(f), 3));
                store_result(3, div_ref(3'(f), a, b));
            end
        end
        end_pc = 32'(ip * 4);
        emit(jtype(21'd0, 0));               // park here
    endtask

    task automatic check_store();
        logic [31:0] ea;
        logic [31:0] ed;
        logic [3:0]  eb;
        if (exp_addr.size() == 0) begin
            $display("store to %h at %0t that the program does not make", o_mem_addr, $time);
            other_errs++;
        end else begin
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            eb = exp_be.pop_front();
            assert (o_mem_addr[31:2] == ea[31:2]) else begin
                $display("[ERROR] %0t o_mem_addr expected %h got %h", $time, ea, o_mem_addr);
                val_errs++;
            end
            assert (o_mem_wdata == ed) else begin
                $display("[ERROR] %0t o_mem_wdata expected %h got %h", $time, ed, o_mem_wdata);
                val_errs++;
            end
            assert (o_wmem == eb) else begin
                $display("[ERROR] %0t o_wmem expected %b got %b", $time, eb, o_wmem);
                val_errs++;
            end
        end
        for (int k = 0; k < 4; k++) begin
            if (o_wmem[k]) begin
                dmem[o_mem_addr[10:2]][8*k +: 8] = o_mem_wdata[8*k +: 8];
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(negedge clk) begin
        if (cycles >= 2) begin
            clrn = 1'b1;                     // reset held for two clocks
        end
        if (clrn) begin
            i_inst = imem[o_pc[11:2]];
        end else begin
            i_inst = stype(12'h000, 5'd0, 5'd0, 3'd2);   // a store word held in reset
        end
        #1 i_mem_rdata = dmem[o_mem_addr[10:2]];   // after the address settles
    end

    always @(posedge clk) begin
        cycles++;
        if (clrn && o_wmem != '0) begin
            check_store();
        end
    end

    initial begin
        foreach (imem[k]) imem[k] = 32'h00000013;   // nop
        foreach (dmem[k]) dmem[k] = 32'h5a3c0000 ^ (32'(k) << 2);
        build_program();
        limit = ip * 34 + 100;
        wait (clrn);
        while (o_pc != end_pc && cycles < limit) begin
            @(negedge clk);
        end
        if (cycles >= limit) begin
            $display("timeout, the program did not reach its final loop in %0d cycles", limit);
            other_errs++;
        end
        if (exp_addr.size() != 0) begin
            $display("%0d expected stores never happened", exp_addr.size());
            other_errs++;
        end
        $display("errors: %0d wrong values, %0d other", val_errs, other_errs);
        if (val_errs + other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- vlog.f
hw/rv32_pkg.sv
hw/rv32_decoder.sv
hw/rv32_regfile.sv
hw/rv32_alu.sv
hw/rv32_divider.sv
hw/rv32_lsu.sv
hw/rv32_core.sv
testbench/rv32_core_props.sv
testbench/tb_rv32_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
TOP       ?= tb_rv32_core
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF "*** TEST FAILED ***" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
